/* rob_defs.svh */
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// Data path and PC width
`define XLEN 32

// Reorder buffer geometry
`define ROB_DEPTH 16
`define ROB_TAG_W 4

// Result buses from the execution units
`define CDB_PORTS 2

// Occupancy at which instr_ready drops
`define ROB_HIGH_WATER 14

`endif

/* riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

  // Major opcodes handled by this core
  typedef enum logic [6:0] {
    OP_IMM = 7'd19,
    AUIPC  = 7'd23,
    OP     = 7'd51,
    LUI    = 7'd55,
    JAL    = 7'd111
  } opcode_e;

  // R-type view; other formats are sliced out of these fields
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode; // May hold codes outside opcode_e
  } rv_instr_t;

  typedef enum logic [4:0] {
    ADD  = 5'd0,
    SUB  = 5'd1,
    AND  = 5'd2,
    OR   = 5'd3,
    XOR  = 5'd4,
    SLL  = 5'd5,
    SRL  = 5'd6,
    SRA  = 5'd7,
    SLT  = 5'd8,
    SLTU = 5'd9
  } alu_op_e;

endpackage

`default_nettype wire

/* rob_pkg.sv */
`default_nettype none

`include "rob_defs.svh"

package rob_pkg;

  import riscv_pkg::*;

  typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

  // Output of the decode stage
  typedef struct packed {
    logic              valid;
    logic              needs_exec; // Clear for LUI, AUIPC, JAL
    alu_op_e           alu_op;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [4:0]        rd;
    logic              use_imm;
    logic [`XLEN-1:0]  imm;
    logic [`XLEN-1:0]  value;      // Locally computed result
  } decoded_t;

  typedef struct packed {
    logic              busy;
    logic              done;
    logic              needs_exec;
    logic [4:0]        rd;
    logic [`XLEN-1:0]  value;
    alu_op_e           alu_op;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic              use_imm;
    logic [`XLEN-1:0]  imm;
  } rob_entry_t;

  typedef struct packed {
    logic              valid;
    rob_tag_t          tag;
    logic [`XLEN-1:0]  value;
  } cdb_t;

  typedef struct packed {
    logic              valid;
    rob_tag_t          tag;
    alu_op_e           alu_op;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic              use_imm;
    logic [`XLEN-1:0]  imm;
  } dispatch_t;

  typedef struct packed {
    logic              valid;
    rob_tag_t          tag;
    logic [4:0]        rd;
    logic [`XLEN-1:0]  value;
  } commit_t;

endpackage

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rv_decode
  import riscv_pkg::*;
  import rob_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             instr_valid,
  input  rv_instr_t        instr,
  input  logic [`XLEN-1:0] instr_pc,
  output decoded_t         decoded
);

  logic [`XLEN-1:0] i_imm;
  logic [`XLEN-1:0] u_imm;
  logic             is_shift;
  alu_op_e          alu_op;
  decoded_t         dec_next;

  assign i_imm    = {{(`XLEN-12){instr.funct7[6]}}, instr.funct7, instr.rs2};
  assign u_imm    = {instr.funct7, instr.rs2, instr.rs1, instr.funct3, 12'b0};
  assign is_shift = (instr.funct3 == 3'b001) || (instr.funct3 == 3'b101);

  always_comb begin
    case (instr.funct3)
      3'b000:  alu_op = (instr.opcode == OP && instr.funct7[5]) ? SUB : ADD; // No SUBI
      3'b001:  alu_op = SLL;
      3'b010:  alu_op = SLT;
      3'b011:  alu_op = SLTU;
      3'b100:  alu_op = XOR;
      3'b101:  alu_op = instr.funct7[5] ? SRA : SRL;
      3'b110:  alu_op = OR;
      default: alu_op = AND;
    endcase
  end

  always_comb begin
    dec_next        = '0;
    dec_next.valid  = instr_valid;
    dec_next.alu_op = alu_op;
    dec_next.rs1    = instr.rs1;
    dec_next.rd     = instr.rd;
    case (instr.opcode)
      OP: begin
        dec_next.needs_exec = 1'b1;
        dec_next.rs2        = instr.rs2;
      end
      OP_IMM: begin
        // rs2 field holds immediate bits here, so rs2 stays x0
        dec_next.needs_exec = 1'b1;
        dec_next.use_imm    = 1'b1;
        dec_next.imm        = is_shift ? {{(`XLEN-5){1'b0}}, instr.rs2} : i_imm;
      end
      LUI:     dec_next.value = u_imm;
      AUIPC:   dec_next.value = u_imm + instr_pc;
      JAL:     dec_next.value = instr_pc + `XLEN'd4; // Link address
      default: dec_next.valid = 1'b0; // Unsupported opcode gets no entry
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      decoded.valid <= 1'b0;
    end else begin
      decoded <= dec_next;
    end
  end

  a_known_opcode: assert property (@(posedge clk) disable iff (reset)
    instr_valid |-> instr.opcode inside {OP_IMM, OP, LUI, AUIPC, JAL});

endmodule

`default_nettype wire

/* rob_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_store
  import rob_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  decoded_t   decoded,
  input  cdb_t       cdb [`CDB_PORTS],
  input  rob_tag_t   dispatch_ptr,
  input  logic       dispatched,
  output rob_tag_t   tail,
  output rob_entry_t disp_entry,
  output logic       instr_ready,
  output commit_t    commit
);

  // One instruction may sit in decode where this block cannot see it
  localparam int unsigned decode_slots = 1;

  rob_entry_t           entries [`ROB_DEPTH];
  rob_tag_t             head;
  logic [`ROB_TAG_W:0]  count;
  logic [`ROB_TAG_W:0]  count_next;
  logic                 alloc;
  logic                 retire;
  rob_entry_t           new_entry;

  assign alloc      = decoded.valid;
  assign retire     = entries[head].busy && entries[head].done;
  assign disp_entry = entries[dispatch_ptr];

  always_comb begin
    new_entry            = '0;
    new_entry.busy       = 1'b1;
    new_entry.done       = !decoded.needs_exec; // Local results are ready now
    new_entry.needs_exec = decoded.needs_exec;
    new_entry.rd         = decoded.rd;
    new_entry.value      = decoded.value;
    new_entry.alu_op     = decoded.alu_op;
    new_entry.rs1        = decoded.rs1;
    new_entry.rs2        = decoded.rs2;
    new_entry.use_imm    = decoded.use_imm;
    new_entry.imm        = decoded.imm;
  end

  always_comb begin
    count_next = count;
    if (alloc && !retire) begin
      count_next = count + 1'b1;
    end else if (!alloc && retire) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      head         <= '0;
      tail         <= '0;
      count        <= '0;
      instr_ready  <= 1'b0;
      commit.valid <= 1'b0;
      for (int i = 0; i < `ROB_DEPTH; i++) begin
        entries[i].busy <= 1'b0;
      end
    end else begin
      count       <= count_next;
      instr_ready <= count_next < (`ROB_HIGH_WATER - decode_slots);

      for (int p = 0; p < `CDB_PORTS; p++) begin
        if (cdb[p].valid) begin
          entries[cdb[p].tag].value <= cdb[p].value;
          entries[cdb[p].tag].done  <= 1'b1;
        end
      end

      if (dispatched) begin
        entries[dispatch_ptr].needs_exec <= 1'b0;
      end

      commit.valid <= retire && (entries[head].rd != 5'd0); // x0 retires silently
      if (retire) begin
        entries[head].busy <= 1'b0;
        head               <= head + 1'b1;
      end

      if (alloc) begin
        entries[tail] <= new_entry;
        tail          <= tail + 1'b1;
      end
    end
    commit.tag   <= head;
    commit.rd    <= entries[head].rd;
    commit.value <= entries[head].value;
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    alloc |-> count < `ROB_DEPTH);

  for (genvar p = 0; p < `CDB_PORTS; p++) begin : g_cdb_chk
    a_cdb_busy: assert property (@(posedge clk) disable iff (reset)
      cdb[p].valid |-> entries[cdb[p].tag].busy);
  end

endmodule

`default_nettype wire

/* rob_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_dispatch
  import rob_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  rob_tag_t   tail,
  input  rob_entry_t disp_entry,
  output rob_tag_t   dispatch_ptr,
  output logic       dispatched,
  output dispatch_t  dispatch
);

  logic pending;
  logic skip;

  // Pointer stays between head and tail, so equality means nothing left
  assign pending    = dispatch_ptr != tail;
  assign dispatched = pending && disp_entry.busy && disp_entry.needs_exec;
  assign skip       = pending && !dispatched;

  always_ff @(posedge clk) begin
    if (reset) begin
      dispatch_ptr   <= '0;
      dispatch.valid <= 1'b0;
    end else begin
      dispatch.valid <= dispatched;
      if (dispatched || skip) begin
        dispatch_ptr <= dispatch_ptr + 1'b1; // One step per cycle
      end
    end
    dispatch.tag     <= dispatch_ptr;
    dispatch.alu_op  <= disp_entry.alu_op;
    dispatch.rs1     <= disp_entry.rs1;
    dispatch.rs2     <= disp_entry.rs2;
    dispatch.use_imm <= disp_entry.use_imm;
    dispatch.imm     <= disp_entry.imm;
  end

endmodule

`default_nettype wire

/* rob_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_top
  import riscv_pkg::*;
  import rob_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             instr_valid,
  input  rv_instr_t        instr,
  input  logic [`XLEN-1:0] instr_pc,
  output logic             instr_ready,
  input  cdb_t             cdb [`CDB_PORTS],
  output dispatch_t        dispatch,
  output commit_t          commit
);

  decoded_t   decoded;
  rob_tag_t   tail;
  rob_tag_t   dispatch_ptr;
  rob_entry_t disp_entry;
  logic       dispatched;

  rv_decode decode_inst (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_pc    (instr_pc),
    .decoded     (decoded)
  );

  rob_store store_inst (
    .clk          (clk),
    .reset        (reset),
    .decoded      (decoded),
    .cdb          (cdb),
    .dispatch_ptr (dispatch_ptr),
    .dispatched   (dispatched),
    .tail         (tail),
    .disp_entry   (disp_entry),
    .instr_ready  (instr_ready),
    .commit       (commit)
  );

  rob_dispatch dispatch_inst (
    .clk          (clk),
    .reset        (reset),
    .tail         (tail),
    .disp_entry   (disp_entry),
    .dispatch_ptr (dispatch_ptr),
    .dispatched   (dispatched),
    .dispatch     (dispatch)
  );

  // Fetch side has no back-pressure path
  a_valid_ready: assert property (@(posedge clk) disable iff (reset)
    instr_valid |-> instr_ready);

endmodule

`default_nettype wire

/* tb_rob.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module tb_rob
  import riscv_pkg::*;
  import rob_pkg::*;
;

  logic             clk;
  logic             reset;
  logic             instr_valid;
  rv_instr_t        instr;
  logic [`XLEN-1:0] instr_pc;
  logic             instr_ready;
  cdb_t             cdb [`CDB_PORTS];
  dispatch_t        dispatch;
  commit_t          commit;

  logic [31:0] lfsr = 32'd48;
  logic [31:0] pc = 32'h1000;
  rv_instr_t   hist_instr [512];
  logic [31:0] hist_pc [512];
  int          exp_disp [$];   // Allocation indices in program order
  int          exp_commit [$];
  int          pend_idx [$];   // Dispatched, result not yet returned
  int          pend_wait [$];
  int          n_alloc = 0;
  int          n_disp = 0;
  int          n_commit = 0;
  int          checks = 0;
  int          errors = 0;
  bit          timed_out = 0;
  bit          cdb_hold = 0;
  string       cur_test = "init";

  rob_top rob_top_inst (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_pc    (instr_pc),
    .instr_ready (instr_ready),
    .cdb         (cdb),
    .dispatch    (dispatch),
    .commit      (commit)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BCD35C) : (lfsr >> 1);
    end
    return r;
  endfunction

  // Expected dispatch fields from the RV32I encoding rules
  function automatic dispatch_t ref_dispatch(logic [31:0] raw);
    dispatch_t d;
    d = '0;
    case (raw[14:12])
      3'd0:    d.alu_op = (raw[6:0] == OP && raw[30]) ? SUB : ADD;
      3'd1:    d.alu_op = SLL;
      3'd2:    d.alu_op = SLT;
      3'd3:    d.alu_op = SLTU;
      3'd4:    d.alu_op = XOR;
      3'd5:    d.alu_op = raw[30] ? SRA : SRL;
      3'd6:    d.alu_op = OR;
      default: d.alu_op = AND;
    endcase
    d.rs1     = raw[19:15];
    d.rs2     = (raw[6:0] == OP) ? raw[24:20] : 5'd0;
    d.use_imm = (raw[6:0] == OP_IMM);
    if (raw[6:0] == OP_IMM) begin
      d.imm = (raw[13:12] == 2'b01) ? {27'd0, raw[24:20]} : {{20{raw[31]}}, raw[31:20]};
    end
    return d;
  endfunction

  function automatic logic [31:0] ref_local(logic [31:0] raw, logic [31:0] addr);
    case (raw[6:0])
      LUI:     return {raw[31:12], 12'd0};
      AUIPC:   return {raw[31:12], 12'd0} + addr;
      default: return addr + 32'd4; // JAL link
    endcase
  endfunction

  function automatic logic [31:0] result_value(int idx);
    return {4'(idx % `ROB_DEPTH), 12'hCDB, 16'(idx)};
  endfunction

  function automatic logic [31:0] expected_value(int idx);
    if (hist_instr[idx].opcode == OP || hist_instr[idx].opcode == OP_IMM) begin
      return result_value(idx);
    end
    return ref_local(hist_instr[idx], hist_pc[idx]);
  endfunction

  function automatic rv_instr_t random_instr(bit alu_only);
    logic [31:0] raw;
    logic [2:0]  kind;
    raw  = take_bits(32);
    kind = 3'(take_bits(3));
    if (alu_only) kind[2] = 1'b0;
    if (take_bits(3) == 0) raw[11:7] = 5'd0; // Some x0 destinations
    case (kind)
      3'd2, 3'd3: begin
        raw[6:0] = OP_IMM;
        if (raw[13:12] == 2'b01) raw[31:25] = (raw[14:12] == 3'd5) ? {1'b0, raw[30], 5'd0} : 7'd0;
      end
      3'd4:    raw[6:0] = LUI;
      3'd5:    raw[6:0] = AUIPC;
      3'd6:    raw[6:0] = JAL;
      default: begin
        raw[6:0]   = OP;
        raw[31:25] = (raw[14:12] == 3'd0 || raw[14:12] == 3'd5) ? {1'b0, raw[30], 5'd0} : 7'd0;
      end
    endcase
    return rv_instr_t'(raw);
  endfunction

  task automatic check_field(string what, logic [31:0] want, logic [31:0] got);
    checks++;
    assert (want == got) else begin
      $display("Error: %s %s expected %h actual %h", cur_test, what, want, got);
      errors++;
    end
  endtask

  task automatic issue(rv_instr_t ins);
    int t;
    t = 0;
    while (!instr_ready && t < 200) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (!instr_ready) begin
      $display("Timeout: instr_ready stayed low in test %s", cur_test);
      timed_out = 1;
    end else begin
      instr_valid         = 1'b1;
      instr               = ins;
      instr_pc            = pc;
      hist_instr[n_alloc] = ins;
      hist_pc[n_alloc]    = pc;
      if (ins.opcode == OP || ins.opcode == OP_IMM) exp_disp.push_back(n_alloc);
      if (ins.rd != 5'd0) exp_commit.push_back(n_alloc);
      n_alloc++;
      pc += 32'd4;
      @(posedge clk);
      #1;
      instr_valid = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while ((exp_disp.size() + exp_commit.size() + pend_idx.size()) != 0 && t < 600) begin
      @(posedge clk);
      #1;
      t++;
    end
    if ((exp_disp.size() + exp_commit.size() + pend_idx.size()) != 0) begin
      $display("Timeout: %0d dispatches and %0d commits never arrived in test %s",
               exp_disp.size(), exp_commit.size(), cur_test);
      timed_out = 1;
    end
  endtask

  task automatic report(int base);
    if (errors == base && !timed_out) $display("test %s: ok", cur_test);
    else $display("test %s: failed, %0d errors", cur_test, errors - base);
  endtask

  // Compares on the falling edge where outputs are stable
  always @(negedge clk) begin
    int idx;
    dispatch_t want;
    if (!reset && dispatch.valid) begin
      n_disp++;
      assert (exp_disp.size() > 0) else begin
        $display("Dispatch of tag %0d was not expected in test %s", dispatch.tag, cur_test);
        errors++;
      end
      if (exp_disp.size() > 0) begin
        idx  = exp_disp.pop_front();
        want = ref_dispatch(hist_instr[idx]);
        check_field("dispatch.tag", idx % `ROB_DEPTH, 32'(dispatch.tag));
        check_field("dispatch.alu_op", 32'(want.alu_op), 32'(dispatch.alu_op));
        check_field("dispatch.rs1", 32'(want.rs1), 32'(dispatch.rs1));
        check_field("dispatch.rs2", 32'(want.rs2), 32'(dispatch.rs2));
        check_field("dispatch.use_imm", 32'(want.use_imm), 32'(dispatch.use_imm));
        check_field("dispatch.imm", want.imm, dispatch.imm);
        pend_idx.push_back(idx);
        pend_wait.push_back(int'(take_bits(3)));
      end
    end
    if (!reset && commit.valid) begin
      n_commit++;
      assert (exp_commit.size() > 0) else begin
        $display("Commit of tag %0d was not expected in test %s", commit.tag, cur_test);
        errors++;
      end
      if (exp_commit.size() > 0) begin
        idx = exp_commit.pop_front();
        check_field("commit.tag", idx % `ROB_DEPTH, 32'(commit.tag));
        check_field("commit.rd", 32'(hist_instr[idx].rd), 32'(commit.rd));
        check_field("commit.value", expected_value(idx), commit.value);
      end
    end
  end

  // Execution unit model returning up to two due results per cycle
  initial begin
    int used;
    int keep_idx [$];
    int keep_wait [$];
    forever begin
      @(posedge clk);
      #1;
      used = 0;
      keep_idx.delete();
      keep_wait.delete();
      for (int p = 0; p < `CDB_PORTS; p++) cdb[p] = '0;
      for (int i = 0; i < pend_idx.size(); i++) begin
        if (!cdb_hold && pend_wait[i] == 0 && used < `CDB_PORTS) begin
          cdb[used].valid = 1'b1;
          cdb[used].tag   = rob_tag_t'(pend_idx[i] % `ROB_DEPTH);
          cdb[used].value = result_value(pend_idx[i]);
          used++;
        end else begin
          keep_idx.push_back(pend_idx[i]);
          keep_wait.push_back((pend_wait[i] == 0) ? 0 : pend_wait[i] - 1);
        end
      end
      pend_idx  = keep_idx;
      pend_wait = keep_wait;
    end
  end

  initial begin
    int base;
    int n;
    int t;
    rv_instr_t seq [7];
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    instr_pc    = '0;
    for (int p = 0; p < `CDB_PORTS; p++) cdb[p] = '0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    cur_test = "reset";
    base     = errors;
    t        = 0;
    while (!instr_ready && t < 10) begin
      check_field("dispatch.valid", 0, 32'(dispatch.valid));
      check_field("commit.valid", 0, 32'(commit.valid));
      @(posedge clk);
      #1;
      t++;
    end
    check_field("instr_ready", 1, 32'(instr_ready));
    report(base);

    if (!timed_out) begin
      cur_test = "random_mix";
      base     = errors;
      for (int i = 0; i < 80; i++) begin
        if (!timed_out) issue(random_instr(1'b0));
      end
      if (!timed_out) wait_drain();
      report(base);
    end

    if (!timed_out) begin
      cur_test = "directed";
      base     = errors;
      seq[0]   = rv_instr_t'({20'hABCDE, 5'd0, LUI});           // x0, no commit
      seq[1]   = rv_instr_t'({12'hFFD, 5'd1, 3'd0, 5'd5, OP_IMM});
      seq[2]   = rv_instr_t'({20'h00100, 5'd0, JAL});
      seq[3]   = rv_instr_t'({7'h20, 5'd7, 5'd5, 3'd0, 5'd6, OP});
      seq[4]   = rv_instr_t'({20'h00010, 5'd8, AUIPC});
      seq[5]   = rv_instr_t'({7'h20, 5'd7, 5'd2, 3'd5, 5'd9, OP_IMM});
      seq[6]   = rv_instr_t'({20'h00200, 5'd1, JAL});
      for (int i = 0; i < 7; i++) begin
        if (!timed_out) issue(seq[i]);
      end
      if (!timed_out) wait_drain();
      report(base);
    end

    if (!timed_out) begin
      cur_test = "occupancy";
      base     = errors;
      cdb_hold = 1'b1;
      n        = 0;
      while (instr_ready && n < 20 && !timed_out) begin
        issue(random_instr(1'b1));
        n++;
      end
      repeat (4) @(posedge clk);
      #1;
      check_field("accepted", `ROB_HIGH_WATER, n);
      check_field("instr_ready", 0, 32'(instr_ready));
      cdb_hold = 1'b0;
      t        = 0;
      while (!instr_ready && t < 100) begin
        @(posedge clk);
        #1;
        t++;
      end
      if (!instr_ready) begin
        $display("Timeout: instr_ready did not rise after the CDB resumed");
        timed_out = 1;
      end else begin
        wait_drain();
      end
      report(base);
    end

    $display("checks %0d, errors %0d, dispatches %0d, commits %0d",
             checks, errors, n_disp, n_commit);
    if (errors == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
riscv_pkg.sv
rob_pkg.sv
rv_decode.sv
rob_store.sv
rob_dispatch.sv
rob_top.sv
tb_rob.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_rob -o tb_rob
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_rob)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^TEST PASSED$"; then
  exit 0
fi
exit 1
